// ==== Makefile ====
TOP = fpCvtTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir

// ==== all.f ====
hdl/fpCvtPkg.sv
hdl/cvtIf.sv
hdl/cvtDecode.sv
hdl/f2iCore.sv
hdl/i2fCore.sv
hdl/cvtExecute.sv
hdl/cvtResult.sv
hdl/fpCvtTop.sv
tb/fpCvt_assertions.sv
tb/fpCvtTb.sv

// ==== hdl/cvtDecode.sv ====
// first pipeline stage, one register; float fields are split even for int-to-float ops
`timescale 1ns/100ps
`default_nettype none

module cvtDecode (
	input  logic            clk,
	input  logic            rst,
	input  logic            inValid, // start strobe
	input  logic [1:0]      op,      // [1] int-to-float, [0] signed
	input  fpCvtPkg::fpWord operand,
	cvtOpIf.drv             dec
);

	// ========================================
	// field split, combinational
	// ========================================
	logic               opSign;
	fpCvtPkg::expField  opExp;
	fpCvtPkg::fracField opMan;
	logic               expZero;  // exponent field all zeros
	logic               expOnes;  // exponent field all ones

	assign opSign  = operand[fpCvtPkg::FpWid-1];
	assign opExp   = operand[fpCvtPkg::FpWid-2 -: fpCvtPkg::ExpWid];
	assign expZero = (opExp == '0);
	assign expOnes = (opExp == '1);

	// hidden bit is 1 unless zero or denormal
	assign opMan = {!expZero, operand[fpCvtPkg::FracWid-1:0]};

	// ========================================
	// stage register
	// ========================================

	// strobe, the only control bit here
	always_ff @(posedge clk) begin
		if (rst) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= inValid;
		end
	end

	// payload carries no reset
	always_ff @(posedge clk) begin
		dec.kind      <= op[1] ? fpCvtPkg::CvtI2F : fpCvtPkg::CvtF2I;
		dec.isSigned  <= op[0];
		dec.operand   <= operand;  // kept whole for the integer path
		dec.sign      <= opSign;
		dec.exp       <= opExp;
		dec.man       <= opMan;
		dec.isZero    <= expZero;  // denormals flush to zero
		dec.isSpecial <= expOnes;  // inf and NaN
	end

endmodule

`default_nettype wire

// ==== hdl/cvtExecute.sv ====
// second stage, both cores run every cycle and the registered kind picks one
`timescale 1ns/100ps
`default_nettype none

module cvtExecute (
	input  logic clk,
	input  logic rst,
	cvtOpIf.rcv  dec,
	cvtResIf.drv res
);

	fpCvtPkg::intWord f2iValue;
	logic             f2iOverflow;
	logic             f2iInexact;
	fpCvtPkg::fpWord  i2fValue;
	logic             i2fInexact;
	logic             validQ;    // lines up with the core registers
	fpCvtPkg::cvtKind kindQ;

	f2iCore f2i (
		.clk      (clk),
		.dec      (dec),
		.value    (f2iValue),
		.overflow (f2iOverflow),
		.inexact  (f2iInexact)
	);

	i2fCore i2f (
		.clk     (clk),
		.dec     (dec),
		.value   (i2fValue),
		.inexact (i2fInexact)
	);

	always_ff @(posedge clk) begin
		if (rst)
			validQ <= 1'b0;
		else
			validQ <= dec.valid;
	end

	always_ff @(posedge clk)
		kindQ <= dec.kind;  // payload, no reset

	// ========================================
	// result select after the core registers
	// ========================================
	assign res.valid    = validQ;
	assign res.value    = (kindQ == fpCvtPkg::CvtI2F) ? i2fValue : fpCvtPkg::fpWord'(f2iValue);
	assign res.overflow = (kindQ == fpCvtPkg::CvtF2I) & f2iOverflow;  // never for int-to-float
	assign res.inexact  = (kindQ == fpCvtPkg::CvtI2F) ? i2fInexact : f2iInexact;

endmodule

`default_nettype wire

// ==== hdl/cvtIf.sv ====
// plain buses between pipeline stages, no handshake and no back-pressure
`timescale 1ns/100ps
`default_nettype none

// ========================================
// decode -> execute
// ========================================
interface cvtOpIf;
	logic               valid;     // operation present in this slot
	fpCvtPkg::cvtKind   kind;      // conversion direction
	logic               isSigned;  // integer side is two's complement
	fpCvtPkg::fpWord    operand;   // raw input word, used by int-to-float
	logic               sign;      // float sign bit
	fpCvtPkg::expField  exp;       // biased exponent
	fpCvtPkg::fracField man;       // mantissa with hidden bit
	logic               isZero;    // zero or denormal
	logic               isSpecial; // exponent all ones, inf or NaN

	modport drv (output valid, kind, isSigned, operand, sign, exp, man, isZero, isSpecial);
	modport rcv (input  valid, kind, isSigned, operand, sign, exp, man, isZero, isSpecial);
endinterface

// ========================================
// execute -> result
// ========================================
interface cvtResIf;
	logic            valid;    // result present
	fpCvtPkg::fpWord value;    // converted word
	logic            overflow; // saturated result, float to int only
	logic            inexact;  // set bits were dropped

	modport drv (output valid, value, overflow, inexact);
	modport rcv (input  valid, value, overflow, inexact);
endinterface

`default_nettype wire

// ==== hdl/cvtResult.sv ====
// output stage; sticky flags OR in each registered result, clrFlags zeroes the old value first
`timescale 1ns/100ps
`default_nettype none

module cvtResult (
	input  logic            clk,
	input  logic            rst,
	cvtResIf.rcv            res,
	input  logic            clrFlags,        // pulse, clears before the new flag is merged
	output logic            outValid,
	output fpCvtPkg::fpWord result,
	output logic            overflow,
	output logic            inexact,
	output logic            stickyOverflow,
	output logic            stickyInexact
);

	logic newOverflow;  // flags of a result present at this edge
	logic newInexact;

	assign newOverflow = res.valid & res.overflow;
	assign newInexact  = res.valid & res.inexact;

	// ========================================
	// output register
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
			overflow <= 1'b0;
			inexact  <= 1'b0;
		end else begin
			outValid <= res.valid;
			overflow <= newOverflow;   // low in empty slots
			inexact  <= newInexact;
		end
	end

	always_ff @(posedge clk)
		result <= res.value;  // data word, no reset

	// ========================================
	// sticky status
	// ========================================

	// same edge as outValid, so a flag shows up together with its result
	always_ff @(posedge clk) begin
		if (rst) begin
			stickyOverflow <= 1'b0;
			stickyInexact  <= 1'b0;
		end else begin
			stickyOverflow <= (stickyOverflow & !clrFlags) | newOverflow;
			stickyInexact  <= (stickyInexact & !clrFlags) | newInexact;  // new flag beats clear
		end
	end

endmodule

`default_nettype wire

// ==== hdl/f2iCore.sv ====
// float to int, round half away from zero, saturating; NaN counts as positive, denormals as zero
`timescale 1ns/100ps
`default_nettype none

module f2iCore (
	input  logic             clk,
	cvtOpIf.rcv              dec,
	output fpCvtPkg::intWord value,
	output logic             overflow,
	output logic             inexact
);

	logic                             isNan;
	logic                             negIn;      // effective sign
	logic                             tiny;       // magnitude below one half
	logic                             ovfSigned;
	logic                             ovfUnsigned;
	logic                             ovf;
	logic [5:0]                       shAmt;      // 0..63 into the fixed point frame
	logic [2*fpCvtPkg::FpWid-1:0]     fixed;      // 32.32 fixed point magnitude
	logic                             guard;      // first bit below the integer part
	logic                             sticky;     // anything further down
	logic                             lost;       // fraction bits dropped
	fpCvtPkg::intWord                 mag;        // rounded magnitude
	fpCvtPkg::intWord                 satVal;
	fpCvtPkg::intWord                 outVal;

	assign isNan = dec.isSpecial & (|dec.man[fpCvtPkg::FracWid-1:0]);
	assign negIn = dec.sign & !isNan;  // NaN saturates like a positive value

	// ========================================
	// range checks on the biased exponent
	// ========================================
	assign tiny = dec.exp < fpCvtPkg::expField'(fpCvtPkg::Bias - 1);

	// 2^32 and up never fits; -2^31 is the only value at 2^31 that fits signed
	assign ovfUnsigned = dec.isSpecial
		| (dec.exp >= fpCvtPkg::expField'(fpCvtPkg::Bias + fpCvtPkg::FpWid))
		| (negIn & !dec.isZero);   // negative input has no unsigned value
	assign ovfSigned = dec.isSpecial
		| (dec.exp >= fpCvtPkg::expField'(fpCvtPkg::Bias + fpCvtPkg::FpWid))
		| ((dec.exp == fpCvtPkg::expField'(fpCvtPkg::Bias + fpCvtPkg::FpWid - 1))
			& !(negIn & (dec.man == {1'b1, {fpCvtPkg::FracWid{1'b0}}})));
	assign ovf = dec.isSigned ? ovfSigned : ovfUnsigned;

	// ========================================
	// align mantissa, round half up on the magnitude
	// ========================================

	// exp 126..158 maps to a left shift of 8..40, so no mantissa bit falls off the bottom
	assign shAmt = 6'(dec.exp
		- fpCvtPkg::expField'(fpCvtPkg::Bias + fpCvtPkg::FracWid - fpCvtPkg::FpWid));
	assign fixed = {{(2*fpCvtPkg::FpWid-fpCvtPkg::FracWid-1){1'b0}}, dec.man} << shAmt;

	assign guard  = fixed[fpCvtPkg::FpWid-1];
	assign sticky = |fixed[fpCvtPkg::FpWid-2:0];
	assign mag    = fixed[2*fpCvtPkg::FpWid-1 -: fpCvtPkg::FpWid] + fpCvtPkg::intWord'(guard);

	// below one half everything nonzero is lost, denormals included
	assign lost = tiny ? (|dec.man) : (guard | sticky);

	always_comb begin
		if (dec.isSigned) begin
			satVal = negIn ? {1'b1, {(fpCvtPkg::FpWid-1){1'b0}}}   // 0x80000000
			               : {1'b0, {(fpCvtPkg::FpWid-1){1'b1}}};  // 0x7FFFFFFF
		end else begin
			satVal = negIn ? '0 : '1;
		end
		if (tiny)
			outVal = '0;
		else if (dec.isSigned & negIn)
			outVal = -mag;  // two's complement before the register
		else
			outVal = mag;
	end

	// registered output, unlike a combinational negate after the register
	always_ff @(posedge clk) begin
		value    <= ovf ? satVal : outVal;
		overflow <= ovf;
		inexact  <= !ovf & lost;   // saturation hides rounding
	end

endmodule

`default_nettype wire

// ==== hdl/fpCvtPkg.sv ====
// single precision only, round modes fixed, no denormal outputs, op[1]=int-to-float op[0]=signed
`default_nettype none

package fpCvtPkg;

	// ========================================
	// field widths of the IEEE 754 single format
	// ========================================
	localparam int FpWid   = 32;  // full word, float and integer alike
	localparam int ExpWid  = 8;   // biased exponent field
	localparam int FracWid = 23;  // stored fraction, hidden bit not included
	localparam int Bias    = 127; // exponent bias

	// ========================================
	// vector types
	// ========================================
	typedef logic [FpWid-1:0]  fpWord;    // raw float bits
	typedef logic [FpWid-1:0]  intWord;   // signed or unsigned integer
	typedef logic [ExpWid-1:0] expField;  // biased exponent
	typedef logic [FracWid:0]  fracField; // mantissa, hidden bit restored at the top

	// direction of the conversion, taken from op[1]
	typedef enum logic {
		CvtF2I = 1'b0, // float to integer
		CvtI2F = 1'b1  // integer to float
	} cvtKind;

endpackage

`default_nettype wire

// ==== hdl/fpCvtTop.sv ====
// fixed three cycle latency, one op per cycle, no stall; outputs follow inValid by three edges
`timescale 1ns/100ps
`default_nettype none

module fpCvtTop (
	input  logic            clk,
	input  logic            rst,            // synchronous, active high
	input  logic            inValid,
	input  logic [1:0]      op,             // [1] int-to-float, [0] signed
	input  fpCvtPkg::fpWord operand,
	input  logic            clrFlags,
	output logic            outValid,
	output fpCvtPkg::fpWord result,
	output logic            overflow,
	output logic            inexact,
	output logic            stickyOverflow,
	output logic            stickyInexact
);

	cvtOpIf  opBus ();   // decode -> execute
	cvtResIf resBus ();  // execute -> result

	// ========================================
	// three register stages
	// ========================================
	cvtDecode decode (
		.clk     (clk),
		.rst     (rst),
		.inValid (inValid),
		.op      (op),
		.operand (operand),
		.dec     (opBus)
	);

	cvtExecute execute (
		.clk (clk),
		.rst (rst),
		.dec (opBus),
		.res (resBus)
	);

	cvtResult resultStage (
		.clk            (clk),
		.rst            (rst),
		.res            (resBus),
		.clrFlags       (clrFlags),
		.outValid       (outValid),
		.result         (result),
		.overflow       (overflow),
		.inexact        (inexact),
		.stickyOverflow (stickyOverflow),
		.stickyInexact  (stickyInexact)
	);

endmodule

`default_nettype wire

// ==== hdl/i2fCore.sv ====
// int to float, round to nearest even only; zero always gives +0
`timescale 1ns/100ps
`default_nettype none

module i2fCore (
	input  logic            clk,
	cvtOpIf.rcv             dec,
	output fpCvtPkg::fpWord value,
	output logic            inexact
);

	logic                         neg;       // negative signed input
	fpCvtPkg::intWord             mag;       // absolute value
	logic                         magZero;
	logic [4:0]                   pos;       // index of the leading one
	fpCvtPkg::intWord             norm;      // leading one moved to the top
	logic                         lsb;       // last kept mantissa bit
	logic                         guard;
	logic                         sticky;
	logic                         roundUp;
	logic [fpCvtPkg::FracWid+1:0] rounded;   // carry, hidden bit, fraction
	fpCvtPkg::expField            expOut;

	// ========================================
	// magnitude and leading one
	// ========================================
	assign neg     = dec.isSigned & dec.operand[fpCvtPkg::FpWid-1];
	assign mag     = neg ? -dec.operand : dec.operand;  // -2^31 stays 0x80000000, fine unsigned
	assign magZero = (mag == '0);

	// priority encoder, highest set bit wins
	always_comb begin
		pos = '0;
		for (int i = 0; i < fpCvtPkg::FpWid; i++) begin
			if (mag[i])
				pos = 5'(i);
		end
	end

	// ========================================
	// normalize and round to nearest even
	// ========================================
	assign norm = mag << (5'(fpCvtPkg::FpWid - 1) - pos);

	// top 24 bits kept, bit 7 is guard, bits 6..0 are sticky
	assign lsb     = norm[fpCvtPkg::FpWid-fpCvtPkg::FracWid-1];
	assign guard   = norm[fpCvtPkg::FpWid-fpCvtPkg::FracWid-2];
	assign sticky  = |norm[fpCvtPkg::FpWid-fpCvtPkg::FracWid-3:0];
	assign roundUp = guard & (sticky | lsb);  // ties go to even

	assign rounded = {1'b0, norm[fpCvtPkg::FpWid-1 -: fpCvtPkg::FracWid+1]}
		+ (fpCvtPkg::FracWid+2)'(roundUp);

	// carry out means mantissa wrapped to 1.0, so bump the exponent
	// and the fraction below is already all zeros
	assign expOut = fpCvtPkg::expField'(pos + fpCvtPkg::Bias + rounded[fpCvtPkg::FracWid+1]);

	always_ff @(posedge clk) begin
		if (magZero)
			value <= '0;   // +0, sign dropped
		else
			value <= {neg, expOut, rounded[fpCvtPkg::FracWid-1:0]};
		inexact <= guard | sticky;  // both zero for a zero input
	end

endmodule

`default_nettype wire

// ==== tb/cvt_cases.txt ====
// ctl operand expected overflow inexact, all hex
// ctl bits: 0 signed, 1 int-to-float, 2 clrFlags on this result, 3 no idle cycle after
1 40200000 00000003 0 1
1 C0200000 FFFFFFFD 0 1
1 3ECCCCCD 00000000 0 1
1 3F000000 00000001 0 1
1 00000000 00000000 0 0
1 00000001 00000000 0 1
1 BFC00000 FFFFFFFE 0 1
1 4F000000 7FFFFFFF 1 0
1 CF000000 80000000 0 0
1 D3800000 80000000 1 0
1 7F800000 7FFFFFFF 1 0
1 FF800000 80000000 1 0
1 FFC00000 7FFFFFFF 1 0
0 4F7FFFFF FFFFFF00 0 0
0 4F800000 FFFFFFFF 1 0
0 BF800000 00000000 1 0
0 80000000 00000000 0 0
0 40600000 00000004 0 1
B 00000001 3F800000 0 0
A 01000001 4B800000 0 1
9 42C80000 00000064 0 0
B FFFFFFFF BF800000 0 0
8 4F800000 FFFFFFFF 1 0
A FFFFFFFF 4F800000 0 1
B 80000000 CF000000 0 0
A 00FFFFFF 4B7FFFFF 0 0
A 01000003 4B800002 0 1
3 FFFFFFF9 C0E00000 0 0
5 3F800000 00000001 0 0
1 4F000000 7FFFFFFF 1 0
3 00000064 42C80000 0 0
7 00000001 3F800000 0 0
5 40200000 00000003 0 1

// ==== tb/fpCvtTb.sv ====
// run from the project root; reads tb/cvt_cases.txt, at most 64 cases, result latency not assumed
`timescale 1ns/100ps
`default_nettype none

module fpCvtTb;

	localparam int MaxCases = 64;
	localparam int Fields   = 5;  // ctl, operand, expected, overflow, inexact

	logic            clk;
	logic            rst;
	logic            inValid;
	logic [1:0]      op;
	fpCvtPkg::fpWord operand;
	logic            clrFlags;
	logic            outValid;
	fpCvtPkg::fpWord result;
	logic            overflow;
	logic            inexact;
	logic            stickyOverflow;
	logic            stickyInexact;

	logic [31:0] caseMem [0:MaxCases*Fields-1];
	logic [33:0] expQ [$];          // {result, overflow, inexact} in issue order
	logic [33:0] want;
	logic [31:0] ctl;
	logic [1:0]  clrLine;           // clear requests on their way to the result edge
	logic        rstSeen;
	logic        clrSeen;
	logic        stickyOvfModel;
	logic        stickyInxModel;
	logic        gotOvf;
	logic        gotInx;
	int          seed = 87178;
	int          nCases;
	int          gap;
	int          waited;
	int          cycles;
	int          limit;
	int          errValue;          // result word mismatches
	int          errFlag;           // overflow or inexact mismatches
	int          errSticky;
	int          errProto;          // result with nothing pending
	int          errDrain;          // results that never came out

	fpCvtTop UUT (.*);

	always #2 clk = ~clk;

	// one negedge step, clear requests reach clrFlags two steps later
	task automatic advance(input logic clrReq);
		clrFlags = clrLine[1];
		clrLine  = {clrLine[0], clrReq};
		@(negedge clk);
	endtask

	// ========================================
	// stimulus
	// ========================================
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		inValid = 1'b0;
		op = 2'b00;
		operand = '0;
		clrFlags = 1'b0;
		clrLine = 2'b00;
		errDrain = 0;
		for (int i = 0; i < MaxCases*Fields; i++)
			caseMem[i] = '1;            // all ones marks the end of the list
		$readmemh("tb/cvt_cases.txt", caseMem);
		nCases = 0;
		while (nCases < MaxCases && caseMem[nCases*Fields] != '1)
			nCases++;
		limit = nCases*3 + 3 + 20;      // worst gap is 2 idle cycles per case
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int c = 0; c < nCases; c++) begin
			ctl     = caseMem[c*Fields];
			op      = ctl[1:0];
			operand = caseMem[c*Fields+1];
			inValid = 1'b1;
			expQ.push_back({caseMem[c*Fields+2], caseMem[c*Fields+3][0], caseMem[c*Fields+4][0]});
			advance(ctl[2]);
			inValid = 1'b0;
			if (!ctl[3]) begin              // bit 3 keeps the next case back to back
				gap = {$random(seed)} % 3;
				repeat (gap) advance(1'b0);
			end
		end
		waited = 0;
		while (expQ.size() != 0 && waited < 8) begin
			advance(1'b0);
			waited++;
		end
		repeat (3) advance(1'b0);       // room for a stray outValid
		if (expQ.size() != 0) begin
			$display("%0d expected results never came out of the DUT", expQ.size());
			errDrain++;
		end
		$display("errors: result %0d, flags %0d, sticky %0d, sequence %0d",
			errValue, errFlag, errSticky, errProto + errDrain);
		if (errValue + errFlag + errSticky + errProto + errDrain == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// inputs are stable at the rising edge
	always @(posedge clk) begin
		rstSeen <= rst;
		clrSeen <= clrFlags;
	end

	// ========================================
	// output check and sticky model
	// ========================================
	initial begin
		errValue = 0;
		errFlag = 0;
		errSticky = 0;
		errProto = 0;
	end

	always @(negedge clk) begin
		gotOvf = 1'b0;
		gotInx = 1'b0;
		if (rstSeen === 1'b1 || rstSeen === 1'bx) begin
			stickyOvfModel = 1'b0;
			stickyInxModel = 1'b0;
		end else begin
			if (outValid) begin
				if (expQ.size() == 0) begin
					$display("at %0t the DUT gave a result with nothing pending", $time);
					errProto++;
				end else begin
					want = expQ.pop_front();
					gotOvf = want[1];
					gotInx = want[0];
					if (result !== want[33:2]) begin
						$display("ERR %0t: result %h, expected %h", $time, result, want[33:2]);
						errValue++;
					end
					if (overflow !== want[1]) begin
						$display("ERR %0t: overflow %b, expected %b", $time, overflow, want[1]);
						errFlag++;
					end
					if (inexact !== want[0]) begin
						$display("ERR %0t: inexact %b, expected %b", $time, inexact, want[0]);
						errFlag++;
					end
				end
			end
			// clear drops the old value, a flag on the same edge still gets in
			stickyOvfModel = (stickyOvfModel & !clrSeen) | gotOvf;
			stickyInxModel = (stickyInxModel & !clrSeen) | gotInx;
			if (stickyOverflow !== stickyOvfModel) begin
				$display("ERR %0t: stickyOverflow %b, expected %b", $time,
					stickyOverflow, stickyOvfModel);
				errSticky++;
			end
			if (stickyInexact !== stickyInxModel) begin
				$display("ERR %0t: stickyInexact %b, expected %b", $time,
					stickyInexact, stickyInxModel);
				errSticky++;
			end
		end
	end

	// ========================================
	// cycle limit
	// ========================================
	initial cycles = 0;

	always @(posedge clk) begin
		if (!rst) begin
			cycles <= cycles + 1;
			if (cycles >= limit) begin
				$display("timeout: run still going after %0d cycles", cycles);
				$display("TEST FAILED");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/fpCvt_assertions.sv ====
// timing and flag qualification only; result values are checked by the testbench
`timescale 1ns/100ps
`default_nettype none

module fpCvtAssertions (
	input logic clk,
	input logic rst,
	input logic inValid,
	input logic outValid,
	input logic overflow,
	input logic inexact,
	input logic stickyOverflow,
	input logic stickyInexact
);

	// ========================================
	// pipeline timing
	// ========================================

	// three register stages, no stall
	latencyCheck: assert property (@(posedge clk) disable iff (rst)
		outValid == $past(inValid, 3))
		else $error("outValid is not inValid delayed by three cycles");

	// flags belong to a result, empty slots carry none
	flagQualCheck: assert property (@(posedge clk) disable iff (rst)
		!outValid |-> (!overflow && !inexact))
		else $error("overflow or inexact high without outValid");

	// ========================================
	// sticky status
	// ========================================
	stickyResetCheck: assert property (@(posedge clk)
		$fell(rst) |-> (!stickyOverflow && !stickyInexact))
		else $error("sticky flags not cleared by reset");

endmodule

bind fpCvtTop fpCvtAssertions timingChecks (
	.clk            (clk),
	.rst            (rst),
	.inValid        (inValid),
	.outValid       (outValid),
	.overflow       (overflow),
	.inexact        (inexact),
	.stickyOverflow (stickyOverflow),
	.stickyInexact  (stickyInexact)
);

`default_nettype wire
